/* ifu_top.f */
+incdir+.
ifu_pkg.sv
ifu_mask_detector.sv
ifu_fetch_window.sv
ifu_align_stage.sv
ifu_issue.sv
ifu_top.sv
tb_ifu.sv

/* run.sh */
#!/usr/bin/env bash
# build the ifu testbench with verilator, run it, look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary -f ifu_top.f --top-module tb_ifu -Mdir obj_dir -o Vtb_ifu \
   || { echo "verilator build failed"; exit 1; }

sim_out="$(./obj_dir/Vtb_ifu)"
echo "$sim_out"

grep -qx "No errors" <<< "$sim_out" && echo "PASS" || { echo "FAIL"; exit 1; }

/* tb_ifu.sv */
`timescale 1ns/1ps

`include "ifu_cfg.svh"

module tb_ifu;

   localparam int CLK_HALF     = 20;
   localparam int RESET_CYCLES = 4;
   localparam int LINE_BYTES   = `IFU_LINE_BYTES;
   localparam int BURST_LEN    = 32;

   // about 600 requests and 300 line loads
   localparam int RAND_CYCLES  = 800;

   // twice the random phase, plus room for directed tests and drain
   localparam int TIMEOUT_CYCLES = 2 * RAND_CYCLES + 400;

   localparam logic [31:0] SEED = 32'h1f9f_c11b;

   logic            clk;
   logic            reset;
   logic            line_valid;
   ifu_pkg::line_t  line_data;
   logic            req;
   ifu_pkg::ofs_t   req_offset;
   ifu_pkg::isize_t req_size;
   logic            window_ready;
   logic            inst_valid;
   ifu_pkg::inst_t  inst;

   // rising edges since time zero
   int cycle;

   logic [31:0] rng_state;

   // window model, current line low
   ifu_pkg::line_t cur_m;
   ifu_pkg::line_t next_m;
   int             fill_m;

   // expected results and the edge each one is due
   ifu_pkg::inst_t exp_q [$];
   int             due_q [$];

   int n_checks;
   int n_errs;
   int n_accepted;

   ifu_top i_dut (
      .clk          (clk),
      .reset        (reset),
      .line_valid   (line_valid),
      .line_data    (line_data),
      .req          (req),
      .req_offset   (req_offset),
      .req_size     (req_size),
      .window_ready (window_ready),
      .inst_valid   (inst_valid),
      .inst         (inst)
   );

   initial begin
      clk = 1'b0;
      forever #CLK_HALF clk = ~clk;
   end

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   task automatic draw(output logic [31:0] r);
      rng_state = xorshift32(rng_state);
      r = rng_state;
   endtask

   // one line of random bytes, word by word
   task automatic make_line(output ifu_pkg::line_t l);
      logic [31:0] r;
      int          w;
      for (w = 0; w < LINE_BYTES / 4; w++) begin
         draw(r);
         l[w*32 +: 32] = r;
      end
   endtask

   // bytes offset .. offset+size-1 land in lanes 0 upward
   // all other lanes zero
   function automatic ifu_pkg::inst_t expect_inst(input ifu_pkg::window_t w,
                                                  input ifu_pkg::ofs_t o,
                                                  input ifu_pkg::isize_t s);
      ifu_pkg::inst_t e;
      int             k;
      e.bytes = '0;
      e.size  = s;
      for (k = 0; k < LINE_BYTES; k++) begin
         if (k < int'(s)) begin
            e.bytes[k*8 +: 8] = w[(int'(o) + k) * 8 +: 8];
         end
      end
      return e;
   endfunction

   task automatic check_bit(input string name, input logic exp, input logic act);
      n_checks++;
      if (act !== exp) begin
         n_errs++;
         $display("ERR %s expected %h actual %h", name, exp, act);
      end
   endtask

   task automatic check_inst(input string name,
                             input ifu_pkg::inst_t exp,
                             input ifu_pkg::inst_t act);
      n_checks++;
      if (act !== exp) begin
         n_errs++;
         $display("ERR %s expected %h actual %h", name, exp, act);
      end
   endtask

   // outputs as left by the edge just passed
   task automatic check_outputs();
      check_bit("window_ready", fill_m == 2, window_ready);
      if (due_q.size() > 0 && due_q[0] == cycle) begin
         check_bit("inst_valid", 1'b1, inst_valid);
         check_inst("inst", exp_q[0], inst);
         // top lane never carries a byte
         check_bit("inst_top_byte_or", 1'b0, |inst.bytes[LINE_BYTES*8-1 -: 8]);
         void'(exp_q.pop_front());
         void'(due_q.pop_front());
      end else begin
         check_bit("inst_valid", 1'b0, inst_valid);
      end
   endtask

   // check after the edge, then drive the next one's inputs
   task automatic run_cycle(input logic do_req,
                            input ifu_pkg::ofs_t ofs,
                            input ifu_pkg::isize_t sz,
                            input logic do_load,
                            input ifu_pkg::line_t data);
      @(posedge clk);
      #1;
      check_outputs();
      #1;
      req        = do_req;
      req_offset = ofs;
      req_size   = sz;
      line_valid = do_load;
      line_data  = data;
      // request sees the window from before a same-edge load
      if (do_req && fill_m == 2) begin
         exp_q.push_back(expect_inst({next_m, cur_m}, ofs, sz));
         // six registers, the first loads on the sampling edge cycle + 1
         due_q.push_back(cycle + `IFU_LATENCY);
         n_accepted++;
      end
      if (do_load) begin
         cur_m  = next_m;
         next_m = data;
         if (fill_m < 2) begin
            fill_m++;
         end
      end
   endtask

   task automatic idle_cycles(input int n);
      repeat (n) begin
         run_cycle(1'b0, 4'd0, 4'd0, 1'b0, '0);
      end
   endtask

   task automatic apply_reset();
      reset = 1'b1;
      repeat (RESET_CYCLES) @(posedge clk);
      #2;
      reset  = 1'b0;
      fill_m = 0;
   endtask

   // random req and load mix
   task automatic random_cycle();
      logic [31:0]    r;
      ifu_pkg::line_t l;
      draw(r);
      make_line(l);
      run_cycle(r[1:0] != 2'b00, r[11:8], r[15:12], r[4:2] < 3'd3, l);
   endtask

   initial begin
      ifu_pkg::line_t l;
      logic [31:0]    r;
      int             i;

      reset      = 1'b1;
      line_valid = 1'b0;
      line_data  = '0;
      req        = 1'b0;
      req_offset = '0;
      req_size   = '0;
      rng_state  = SEED;
      fill_m     = 0;
      cur_m      = '0;
      next_m     = '0;
      n_checks   = 0;
      n_errs     = 0;
      n_accepted = 0;

      apply_reset();

      // empty window, nothing ready
      idle_cycles(3);
      draw(r);
      run_cycle(1'b1, r[3:0], r[7:4], 1'b0, '0);
      // first line, req on the same edge still refused
      make_line(l);
      run_cycle(1'b1, 4'd3, 4'd5, 1'b1, l);
      // one line only
      run_cycle(1'b1, 4'd0, 4'd8, 1'b0, '0);
      make_line(l);
      run_cycle(1'b0, 4'd0, 4'd0, 1'b1, l);
      // early requests must never surface
      idle_cycles(`IFU_LATENCY + 2);

      // size 0 gives an empty instruction
      draw(r);
      run_cycle(1'b1, r[3:0], 4'd0, 1'b0, '0);
      // longest instruction from the last byte, crosses into next line
      run_cycle(1'b1, 4'd15, 4'd15, 1'b0, '0);
      run_cycle(1'b1, 4'd0, 4'd15, 1'b0, '0);
      run_cycle(1'b1, 4'd15, 4'd1, 1'b0, '0);
      idle_cycles(2);

      // load with req on one edge, then the same req on the new window
      make_line(l);
      run_cycle(1'b1, 4'd4, 4'd12, 1'b1, l);
      run_cycle(1'b1, 4'd4, 4'd12, 1'b0, '0);
      idle_cycles(`IFU_LATENCY + 1);

      // back to back requests, one result per cycle
      for (i = 0; i < BURST_LEN; i++) begin
         draw(r);
         run_cycle(1'b1, r[3:0], r[7:4], 1'b0, '0);
      end
      idle_cycles(`IFU_LATENCY + 1);

      for (i = 0; i < RAND_CYCLES; i++) begin
         random_cycle();
      end

      // drain what is still in flight
      while (exp_q.size() > 0) begin
         idle_cycles(1);
      end
      idle_cycles(`IFU_LATENCY + 2);

      $display("checks %0d, requests accepted %0d, errors %0d",
               n_checks, n_accepted, n_errs);
      if (n_errs == 0) begin
         $display("No errors");
      end else begin
         $display("Errors found");
      end
      $finish;
   end

   // watchdog on the edge count
   initial begin
      cycle = 0;
      while (cycle < TIMEOUT_CYCLES) begin
         @(posedge clk);
         cycle = cycle + 1;
      end
      $display("timeout: run still going after %0d cycles, %0d results outstanding",
               cycle, exp_q.size());
      $display("checks %0d, requests accepted %0d, errors %0d",
               n_checks, n_accepted, n_errs);
      $display("Errors found");
      $finish;
   end

endmodule

/* ifu_top.sv */
`timescale 1ns/1ps

`include "ifu_cfg.svh"

module ifu_top (
   input  logic            clk,
   input  logic            reset,
   input  logic            line_valid,
   input  ifu_pkg::line_t  line_data,
   input  logic            req,
   input  ifu_pkg::ofs_t   req_offset,
   input  ifu_pkg::isize_t req_size,
   output logic            window_ready,
   output logic            inst_valid,
   output ifu_pkg::inst_t  inst
);

   // packet between pipeline stages
   // entry 0 from the window, last entry into issue
   ifu_pkg::fetch_pkt_t stage_pkt [0:`IFU_ALIGN_STAGES];

   ifu_fetch_window u_fetch_window (
      .clk          (clk),
      .reset        (reset),
      .line_valid   (line_valid),
      .line_data    (line_data),
      .req          (req),
      .req_offset   (req_offset),
      .req_size     (req_size),
      .window_ready (window_ready),
      .pkt          (stage_pkt[0])
   );

   // log shifter, stage i moves 2**i bytes
   for (genvar i = 0; i < `IFU_ALIGN_STAGES; i++) begin : g_align
      ifu_align_stage #(
         .SHIFT_BYTES (1 << i)
      ) u_align_stage (
         .clk     (clk),
         .reset   (reset),
         .pkt_in  (stage_pkt[i]),
         .pkt_out (stage_pkt[i+1])
      );
   end

   ifu_issue u_issue (
      .clk        (clk),
      .reset      (reset),
      .pkt        (stage_pkt[`IFU_ALIGN_STAGES]),
      .inst_valid (inst_valid),
      .inst       (inst)
   );

endmodule

/* ifu_issue.sv */
`timescale 1ns/1ps

module ifu_issue (
   input  logic                clk,
   input  logic                reset,
   input  ifu_pkg::fetch_pkt_t pkt,
   output logic                inst_valid,
   output ifu_pkg::inst_t      inst
);

   localparam int LINE_BITS = $bits(ifu_pkg::line_t);

   // byte enables for the instruction length
   ifu_pkg::line_t byte_mask;

   // low line of the fully rotated window
   ifu_pkg::line_t aligned_line;

   logic           inst_valid_q;
   ifu_pkg::inst_t inst_q;

   ifu_mask_detector u_mask_detector (
      .size (pkt.size),
      .mask (byte_mask)
   );

   // instruction start already sits in lane 0
   assign aligned_line = pkt.window[LINE_BITS-1:0];

   // issue valid
   always_ff @(posedge clk) begin
      if (reset) begin
         inst_valid_q <= 1'b0;
      end else begin
         inst_valid_q <= pkt.valid;
      end
   end

   // bytes past the length are zeroed
   always_ff @(posedge clk) begin
      inst_q.bytes <= aligned_line & byte_mask;
      inst_q.size  <= pkt.size;
   end

   assign inst_valid = inst_valid_q;
   assign inst       = inst_q;

endmodule

/* ifu_align_stage.sv */
`timescale 1ns/1ps

module ifu_align_stage #(
   // byte distance of this stage, power of two below 16
   parameter int SHIFT_BYTES = 1
) (
   input  logic                clk,
   input  logic                reset,
   input  ifu_pkg::fetch_pkt_t pkt_in,
   output ifu_pkg::fetch_pkt_t pkt_out
);

   // offset bit that enables this stage
   localparam int SEL_BIT = $clog2(SHIFT_BYTES);

   // window after the conditional rotate
   ifu_pkg::window_t window_shifted;

   ifu_pkg::fetch_pkt_t pkt_q;

   // move the window down when the offset bit is set
   // upper bytes fill with zero
   always_comb begin
      if (pkt_in.offset[SEL_BIT]) begin
         window_shifted = pkt_in.window >> (SHIFT_BYTES * 8);
      end else begin
         window_shifted = pkt_in.window;
      end
   end

   // stage register
   always_ff @(posedge clk) begin
      if (reset) begin
         pkt_q.valid <= 1'b0;
      end else begin
         pkt_q.valid <= pkt_in.valid;
      end
      // offset and size ride along for later stages
      pkt_q.window <= window_shifted;
      pkt_q.offset <= pkt_in.offset;
      pkt_q.size   <= pkt_in.size;
   end

   assign pkt_out = pkt_q;

endmodule

/* ifu_fetch_window.sv */
`timescale 1ns/1ps

module ifu_fetch_window (
   input  logic               clk,
   input  logic               reset,
   input  logic               line_valid,
   input  ifu_pkg::line_t     line_data,
   input  logic               req,
   input  ifu_pkg::ofs_t      req_offset,
   input  ifu_pkg::isize_t    req_size,
   output logic               window_ready,
   output ifu_pkg::fetch_pkt_t pkt
);

   // two line slots of the window
   ifu_pkg::line_t cur_line;
   ifu_pkg::line_t next_line;

   // lines loaded so far, stops at two
   logic [1:0] fill_cnt;

   // request taken this cycle
   logic accept;

   // launched packet
   ifu_pkg::fetch_pkt_t pkt_q;

   // window usable once both slots hold data
   assign window_ready = (fill_cnt == 2'd2);

   // only a full window takes a request
   assign accept = req & window_ready;

   // fill counter
   always_ff @(posedge clk) begin
      if (reset) begin
         fill_cnt <= 2'd0;
      end else if (line_valid && (fill_cnt != 2'd2)) begin
         fill_cnt <= fill_cnt + 2'd1;
      end
   end

   // line slots shift on every load
   // next slot moves down, new line lands on top
   always_ff @(posedge clk) begin
      if (line_valid) begin
         cur_line  <= next_line;
         next_line <= line_data;
      end
   end

   // packet launch
   // window sampled before any load on this edge
   always_ff @(posedge clk) begin
      if (reset) begin
         pkt_q.valid <= 1'b0;
      end else begin
         pkt_q.valid <= accept;
      end
      // payload only captured for accepted requests
      if (accept) begin
         pkt_q.window <= {next_line, cur_line};
         pkt_q.offset <= req_offset;
         pkt_q.size   <= req_size;
      end
   end

   // head of the align chain
   assign pkt = pkt_q;

endmodule

/* ifu_mask_detector.sv */
`timescale 1ns/1ps

module ifu_mask_detector (
   input  ifu_pkg::isize_t size,
   output ifu_pkg::line_t  mask
);

   // shared product terms of the size bits
   logic p_3210;
   logic p_321;
   logic p_320;
   logic p_32;
   logic p_310;
   logic p_31;
   logic p_30;
   logic p_210;
   logic p_21;
   logic p_20;
   logic p_10;

   // one enable per kept byte, byte 15 never kept
   logic [14:0] bitmask;

   assign p_3210 = size[3] & size[2] & size[1] & size[0];
   assign p_321  = size[3] & size[2] & size[1];
   assign p_320  = size[3] & size[2] & size[0];
   assign p_32   = size[3] & size[2];
   assign p_310  = size[3] & size[1] & size[0];
   assign p_31   = size[3] & size[1];
   assign p_30   = size[3] & size[0];
   assign p_210  = size[2] & size[1] & size[0];
   assign p_21   = size[2] & size[1];
   assign p_20   = size[2] & size[0];
   assign p_10   = size[1] & size[0];

   // byte k is kept when size exceeds k
   assign bitmask[14] = p_3210;
   assign bitmask[13] = p_321;
   assign bitmask[12] = p_320 | p_321;
   assign bitmask[11] = p_32;
   assign bitmask[10] = p_310 | p_32;
   assign bitmask[9]  = p_31 | p_32;
   assign bitmask[8]  = p_30 | p_31 | p_32;
   // any size from 8 up
   assign bitmask[7]  = size[3];
   assign bitmask[6]  = p_210 | size[3];
   assign bitmask[5]  = p_21 | size[3];
   assign bitmask[4]  = p_20 | p_21 | size[3];
   assign bitmask[3]  = size[2] | size[3];
   assign bitmask[2]  = p_10 | size[2] | size[3];
   assign bitmask[1]  = size[1] | size[2] | size[3];
   // anything but size 0
   assign bitmask[0]  = size[0] | size[1] | size[2] | size[3];

   // spread each byte enable over its eight bits
   for (genvar k = 0; k < 15; k++) begin : g_lane
      assign mask[k*8 +: 8] = {8{bitmask[k]}};
   end

   // top lane always cleared
   assign mask[127:120] = 8'h00;

endmodule

/* ifu_pkg.sv */
`include "ifu_cfg.svh"

package ifu_pkg;

   // one cache line of raw bytes
   typedef logic [`IFU_LINE_BYTES*8-1:0] line_t;

   // two consecutive lines
   // current line sits in the low bytes
   typedef logic [2*`IFU_LINE_BYTES*8-1:0] window_t;

   // start byte within the current line
   typedef logic [$clog2(`IFU_LINE_BYTES)-1:0] ofs_t;

   // instruction length in bytes, 0 to 15
   typedef logic [3:0] isize_t;

   // request travelling the rotate pipeline
   typedef struct packed {
      logic    valid;
      window_t window;
      ofs_t    offset;
      isize_t  size;
   } fetch_pkt_t;

   // aligned instruction as issued
   // byte 0 of the instruction in lane 0
   typedef struct packed {
      line_t  bytes;
      isize_t size;
   } inst_t;

endpackage

/* ifu_cfg.svh */
`ifndef IFU_CFG_SVH
`define IFU_CFG_SVH

// fetch unit build constants

// bytes held by one cache line
`define IFU_LINE_BYTES 16

// rotate stages in the aligner
// log2 of the line bytes
`define IFU_ALIGN_STAGES 4

// req sample edge to inst_valid
// window 1 + align 4 + issue 1
`define IFU_LATENCY 6

`endif
